// File: src.f
+incdir+verilog
verilog/ts3d_pkg.sv
verilog/gbf_ram.sv
verilog/word_unpacker.sv
verilog/gbf_reader.sv
verilog/act_dispatch.sv
verilog/ts3d_act_feed.sv
testbench/tb_ts3d_act_feed.sv

// File: Makefile
# Verilator build and run for the activation feed path

TOP = tb_ts3d_act_feed

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -Wno-fatal -f src.f --top-module $(TOP) -o sim_$(TOP)

run: build
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "Everything OK" sim.log

lint:
	verilator --lint-only --timing -Wall -f src.f --top-module ts3d_act_feed

clean:
	rm -rf obj_dir sim.log

// File: testbench/tb_ts3d_act_feed.sv
// clock, reset, directed tests, compare tasks and timeout for the activation feed top level
`timescale 1ns/1ns
`include "ts3d_settings.svh"

module tb_ts3d_act_feed
    import ts3d_pkg::*;
();

    // at most 36 blocks are fetched over all tests
    localparam int EXP_BLOCKS  = 36;
    localparam int CYCLE_LIMIT = 40 * EXP_BLOCKS + 200;

    logic       clk;
    logic       rst_n;
    gbf_wr_t    act_wr;
    gbf_wr_t    flg_wr;
    logic       fetch;
    logic       act_rdy;
    act_block_t block;

    // next buffer addresses wrap at the buffer depth
    logic [`TS3D_GBF_ADDR_WIDTH-1:0] act_addr;
    logic [`TS3D_GBF_ADDR_WIDTH-1:0] flg_addr;

    // reference streams in write order
    logic [`TS3D_DATA_WIDTH-1:0]  act_ref[$];
    logic [`TS3D_BLOCK_DEPTH-1:0] flg_ref[$];

    // values waiting to fill one port word
    logic [`TS3D_DATA_WIDTH-1:0]  act_stage[$];
    logic [`TS3D_BLOCK_DEPTH-1:0] flg_stage[$];

    int errors = 0;
    int checks = 0;
    int cycles = 0;

    ts3d_act_feed UUT (
        .clk     (clk),
        .rst_n   (rst_n),
        .act_wr  (act_wr),
        .flg_wr  (flg_wr),
        .fetch   (fetch),
        .act_rdy (act_rdy),
        .block   (block)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: no end of test after %0d cycles", cycles);
            $display("Something failed");
            $finish;
        end
    end

    // ============================================================
    // compare tasks
    // ============================================================

    task automatic cmp_block(input act_block_t got, input act_block_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic cmp_bit(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t ns: %s, got %b, expected %b", $time, what, got, exp);
        end
    endtask

    // ============================================================
    // buffer writes
    // ============================================================

    task automatic write_act_word(input gbf_word_t w);
        @(negedge clk);
        act_wr.en   = 1'b1;
        act_wr.addr = act_addr;
        act_wr.data = w;
        @(negedge clk);
        act_wr.en = 1'b0;
        act_addr  = act_addr + 1'b1;
    endtask

    task automatic write_flg_word(input gbf_word_t w);
        @(negedge clk);
        flg_wr.en   = 1'b1;
        flg_wr.addr = flg_addr;
        flg_wr.data = w;
        @(negedge clk);
        flg_wr.en = 1'b0;
        flg_addr  = flg_addr + 1'b1;
    endtask

    // packs bytes through the byte view with element 0 lowest
    task automatic queue_act(input logic [`TS3D_DATA_WIDTH-1:0] v);
        gbf_word_t w;
        act_ref.push_back(v);
        act_stage.push_back(v);
        if (act_stage.size() == `TS3D_ACTS_PER_WORD) begin
            for (int i = 0; i < `TS3D_ACTS_PER_WORD; i++) begin
                w.act[i] = act_stage[i];
            end
            act_stage.delete();
            write_act_word(w);
        end
    endtask

    // packs vectors through the flag view with vector 0 lowest
    task automatic queue_flag(input logic [`TS3D_BLOCK_DEPTH-1:0] v);
        gbf_word_t w;
        flg_ref.push_back(v);
        flg_stage.push_back(v);
        if (flg_stage.size() == `TS3D_FLGS_PER_WORD) begin
            for (int i = 0; i < `TS3D_FLGS_PER_WORD; i++) begin
                w.flg[i] = flg_stage[i];
            end
            flg_stage.delete();
            write_flg_word(w);
        end
    endtask

    // padding belongs to the stream and zero flags make empty blocks
    task automatic pad_acts();
        while (act_stage.size() != 0) begin
            queue_act('0);
        end
    endtask

    task automatic pad_flags();
        while (flg_stage.size() != 0) begin
            queue_flag('0);
        end
    endtask

    // one random vector and a nonzero value for each set bit
    task automatic queue_sparse(input logic [`TS3D_BLOCK_DEPTH-1:0] v);
        queue_flag(v);
        repeat ($countones(v)) begin
            queue_act(`TS3D_DATA_WIDTH'($urandom_range(1, 255)));
        end
    endtask

    // ============================================================
    // block handling
    // ============================================================

    // next queued value goes to each set bit and zero elsewhere
    function automatic act_block_t expect_block();
        act_block_t exp;
        exp       = '0;
        exp.flags = flg_ref.pop_front();
        for (int i = 0; i < `TS3D_BLOCK_DEPTH; i++) begin
            if (exp.flags[i]) begin
                exp.acts[i] = act_ref.pop_front();
            end
        end
        return exp;
    endfunction

    task automatic pulse_fetch();
        @(negedge clk);
        fetch = 1'b1;
        @(negedge clk);
        fetch = 1'b0;
        cmp_bit(act_rdy, 1'b0, "act_rdy the cycle after fetch");
    endtask

    task automatic wait_ready();
        while (!act_rdy) begin
            @(negedge clk);
        end
    endtask

    task automatic run_block(input string what);
        act_block_t exp;
        pulse_fetch();
        wait_ready();
        exp = expect_block();
        cmp_block(block, exp, what);
    endtask

    task automatic fetch_all(input string what);
        while (flg_ref.size() > 0) begin
            run_block(what);
        end
    endtask

    // uses up every written value so the activation buffer runs dry
    task automatic drain_acts();
        int n;
        int k;
        n = act_ref.size();
        while (n > 0) begin
            k = (n > `TS3D_BLOCK_DEPTH) ? `TS3D_BLOCK_DEPTH : n;
            queue_flag(`TS3D_BLOCK_DEPTH'((17'h1 << k) - 1));
            n = n - k;
        end
        pad_flags();
        fetch_all("drain block");
    endtask

    // ============================================================
    // directed tests
    // ============================================================

    task automatic test_idle();
        cmp_bit(act_rdy, 1'b0, "act_rdy after reset");
        queue_flag(16'hffff);
        pad_flags();
        repeat (`TS3D_BLOCK_DEPTH) begin
            queue_act(`TS3D_DATA_WIDTH'($urandom_range(1, 255)));
        end
        pad_acts();
        repeat (20) begin
            @(negedge clk);
            cmp_bit(act_rdy, 1'b0, "act_rdy without fetch");
        end
    endtask

    task automatic test_dense();
        run_block("dense block");
        fetch_all("padding block");
    endtask

    task automatic test_sparse();
        repeat (12) begin
            queue_sparse(`TS3D_BLOCK_DEPTH'($urandom));
        end
        pad_flags();
        pad_acts();
        fetch_all("sparse block");
    endtask

    task automatic test_zero();
        queue_flag('0);
        queue_sparse(`TS3D_BLOCK_DEPTH'($urandom_range(1, 16'hffff)));
        pad_flags();
        pad_acts();
        fetch_all("zero flag and following block");
    endtask

    task automatic test_backpressure();
        act_block_t held;
        act_block_t exp;
        int         gap;
        repeat (8) begin
            queue_sparse(`TS3D_BLOCK_DEPTH'($urandom));
        end
        pad_flags();
        pad_acts();
        while (flg_ref.size() > 0) begin
            pulse_fetch();
            wait_ready();
            held = block;
            gap  = $urandom_range(1, 8);
            repeat (gap) begin
                @(negedge clk);
                cmp_bit(act_rdy, 1'b1, "act_rdy held without fetch");
                cmp_block(block, held, "block held without fetch");
            end
            exp = expect_block();
            cmp_block(held, exp, "buffered block");
        end
    endtask

    task automatic test_starve();
        act_block_t                   exp;
        logic [`TS3D_BLOCK_DEPTH-1:0] v;
        drain_acts();
        v = `TS3D_BLOCK_DEPTH'($urandom_range(1, 16'hffff));
        queue_flag(v);
        pad_flags();
        pulse_fetch();
        repeat (30) begin
            @(negedge clk);
            cmp_bit(act_rdy, 1'b0, "act_rdy with no activations");
        end
        repeat ($countones(v)) begin
            queue_act(`TS3D_DATA_WIDTH'($urandom_range(1, 255)));
        end
        pad_acts();
        wait_ready();
        exp = expect_block();
        cmp_block(block, exp, "block after late activations");
        fetch_all("padding block");
    endtask

    // ============================================================
    // main sequence
    // ============================================================

    initial begin
        clk      = 1'b0;
        rst_n    = 1'b0;
        act_wr   = '0;
        flg_wr   = '0;
        fetch    = 1'b0;
        act_addr = '0;
        flg_addr = '0;
        void'($urandom(90621));
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        test_idle();
        test_dense();
        test_sparse();
        test_zero();
        test_backpressure();
        test_starve();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: verilog/ts3d_act_feed.sv
// top level with activation and flag buffer readers and dispatcher
`timescale 1ns/1ns
`include "ts3d_settings.svh"

module ts3d_act_feed
    import ts3d_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  gbf_wr_t    act_wr,
    input  gbf_wr_t    flg_wr,
    input  logic       fetch,
    output logic       act_rdy,
    output act_block_t block
);

    // activation slice path
    logic                         act_slice_rdy;
    logic                         act_slice_take;
    logic [`TS3D_DATA_WIDTH-1:0]  act_slice;

    // flag vector path
    logic                         flg_slice_rdy;
    logic                         flg_slice_take;
    logic [`TS3D_BLOCK_DEPTH-1:0] flg_slice;

    // ============================================================
    // global buffers
    // ============================================================

    gbf_reader #(
        .SLICE_WIDTH (`TS3D_DATA_WIDTH)
    ) u_act_gbf (
        .clk        (clk),
        .rst_n      (rst_n),
        .wr         (act_wr),
        .slice_rdy  (act_slice_rdy),
        .slice_take (act_slice_take),
        .slice      (act_slice)
    );

    gbf_reader #(
        .SLICE_WIDTH (`TS3D_BLOCK_DEPTH)
    ) u_flg_gbf (
        .clk        (clk),
        .rst_n      (rst_n),
        .wr         (flg_wr),
        .slice_rdy  (flg_slice_rdy),
        .slice_take (flg_slice_take),
        .slice      (flg_slice)
    );

    // ============================================================
    // dispatcher
    // ============================================================

    act_dispatch u_dispatch (
        .clk        (clk),
        .rst_n      (rst_n),
        .fetch      (fetch),
        .flg_rdy    (flg_slice_rdy),
        .flg_slice  (flg_slice),
        .flg_take   (flg_slice_take),
        .act_rdy_in (act_slice_rdy),
        .act_slice  (act_slice),
        .act_take   (act_slice_take),
        .act_rdy    (act_rdy),
        .block      (block)
    );

endmodule

// File: verilog/act_dispatch.sv
// scatters nonzero activations into a dense block by flags
`timescale 1ns/1ns
`include "ts3d_settings.svh"

module act_dispatch
    import ts3d_pkg::*;
(
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         fetch,
    input  logic                         flg_rdy,
    input  logic [`TS3D_BLOCK_DEPTH-1:0] flg_slice,
    output logic                         flg_take,
    input  logic                         act_rdy_in,
    input  logic [`TS3D_DATA_WIDTH-1:0]  act_slice,
    output logic                         act_take,
    output logic                         act_rdy,
    output act_block_t                   block
);

    localparam int POS_WIDTH = $clog2(`TS3D_BLOCK_DEPTH);

    // FSM encoding
    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_FLG  = 2'd1;
    localparam logic [1:0] ST_FILL = 2'd2;
    localparam logic [1:0] ST_DONE = 2'd3;

    logic [1:0]                   state_q;
    logic [`TS3D_BLOCK_DEPTH-1:0] pend_q;
    logic [`TS3D_BLOCK_DEPTH-1:0] pend_rest;
    logic [POS_WIDTH-1:0]         pos;
    logic                         start;
    act_block_t                   block_q;

    // ============================================================
    // scatter position
    // ============================================================

    // lowest flag bit still waiting for its activation
    always_comb begin
        pos = '0;
        for (int i = `TS3D_BLOCK_DEPTH - 1; i >= 0; i--) begin
            if (pend_q[i]) begin
                pos = POS_WIDTH'(i);
            end
        end
    end

    // pending bits once the lowest one is served
    assign pend_rest = pend_q & (pend_q - 1'b1);

    // a new block starts only from idle or after the last one was released
    assign start = fetch && ((state_q == ST_IDLE) || (state_q == ST_DONE));

    assign flg_take = (state_q == ST_FLG) && flg_rdy;
    assign act_take = (state_q == ST_FILL) && act_rdy_in;

    // ============================================================
    // FSM
    // ============================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
            pend_q  <= '0;
        end else begin
            case (state_q)
                ST_IDLE, ST_DONE: begin
                    if (start) begin
                        state_q <= ST_FLG;
                    end
                end
                ST_FLG: begin
                    if (flg_take) begin
                        pend_q <= flg_slice;
                        // empty vector needs no activation at all
                        state_q <= (flg_slice == '0) ? ST_DONE : ST_FILL;
                    end
                end
                ST_FILL: begin
                    if (act_take) begin
                        pend_q <= pend_rest;
                        if (pend_rest == '0) begin
                            state_q <= ST_DONE;
                        end
                    end
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    // ============================================================
    // block register
    // ============================================================

    // unflagged positions keep the zero written at start
    always_ff @(posedge clk) begin
        if (start) begin
            block_q <= '0;
        end else if (flg_take) begin
            block_q.flags <= flg_slice;
        end else if (act_take) begin
            block_q.acts[pos] <= act_slice;
        end
    end

    assign block   = block_q;
    assign act_rdy = (state_q == ST_DONE);

endmodule

// File: verilog/gbf_reader.sv
// one global buffer with occupancy, read control and unpacker
`timescale 1ns/1ns
`include "ts3d_settings.svh"

module gbf_reader
    import ts3d_pkg::*;
#(
    parameter int SLICE_WIDTH = 8
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  gbf_wr_t                wr,
    output logic                   slice_rdy,
    input  logic                   slice_take,
    output logic [SLICE_WIDTH-1:0] slice
);

    logic [`TS3D_GBF_CNT_WIDTH-1:0]  occ_q;
    logic [`TS3D_GBF_ADDR_WIDTH-1:0] rd_addr_q;
    logic                            in_flight_q;
    logic                            rd_en;
    logic                            unp_empty;
    gbf_word_t                       rd_data;

    // ============================================================
    // read control
    // ============================================================

    // fetch one word when the unpacker has run dry and nothing is
    // already on its way out of the RAM
    assign rd_en = unp_empty && (occ_q != '0) && !in_flight_q;

    // a write and a read in the same cycle leave occupancy unchanged
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            occ_q <= '0;
        end else if (wr.en && !rd_en) begin
            occ_q <= occ_q + 1'b1;
        end else if (rd_en && !wr.en) begin
            occ_q <= occ_q - 1'b1;
        end
    end

    // read address wraps with the write side
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_addr_q <= '0;
        end else if (rd_en) begin
            rd_addr_q <= rd_addr_q + 1'b1;
        end
    end

    // high for the cycle in which RAM data is valid
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_flight_q <= 1'b0;
        end else begin
            in_flight_q <= rd_en;
        end
    end

    // ============================================================
    // buffer memory and unpacker
    // ============================================================

    gbf_ram u_ram (
        .clk     (clk),
        .wr      (wr),
        .rd_en   (rd_en),
        .rd_addr (rd_addr_q),
        .rd_data (rd_data)
    );

    word_unpacker #(
        .SLICE_WIDTH (SLICE_WIDTH)
    ) u_unpacker (
        .clk        (clk),
        .rst_n      (rst_n),
        .load       (in_flight_q),
        .word       (rd_data),
        .empty      (unp_empty),
        .slice_rdy  (slice_rdy),
        .slice_take (slice_take),
        .slice      (slice)
    );

endmodule

// File: verilog/word_unpacker.sv
// holds one port word and hands out fixed-width slices
`timescale 1ns/1ns
`include "ts3d_settings.svh"

module word_unpacker #(
    parameter int SLICE_WIDTH = 8
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        load,
    input  logic [`TS3D_PORT_WIDTH-1:0] word,
    output logic                        empty,
    output logic                        slice_rdy,
    input  logic                        slice_take,
    output logic [SLICE_WIDTH-1:0]      slice
);

    localparam int NUM_SLICES = `TS3D_PORT_WIDTH / SLICE_WIDTH;
    localparam int IDX_WIDTH  = $clog2(NUM_SLICES + 1);

    // ============================================================
    // held word and slice index
    // ============================================================

    // word_q shifts down so the current slice is always at the bottom
    logic [`TS3D_PORT_WIDTH-1:0] word_q;

    // number of slices still left in word_q
    logic [IDX_WIDTH-1:0] left_q;

    logic take_ok;

    assign take_ok = slice_take && slice_rdy;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            left_q <= '0;
        end else if (load) begin
            left_q <= IDX_WIDTH'(NUM_SLICES);
        end else if (take_ok) begin
            left_q <= left_q - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            word_q <= word;
        end else if (take_ok) begin
            word_q <= word_q >> SLICE_WIDTH;
        end
    end

    // ============================================================
    // outputs
    // ============================================================

    assign empty     = (left_q == '0);
    assign slice_rdy = !empty;

    // lowest slice of what is left
    assign slice = word_q[SLICE_WIDTH-1:0];

endmodule

// File: verilog/gbf_ram.sv
// simple dual-port global buffer memory with registered read
`timescale 1ns/1ns
`include "ts3d_settings.svh"

module gbf_ram
    import ts3d_pkg::*;
(
    input  logic                            clk,
    input  gbf_wr_t                         wr,
    input  logic                            rd_en,
    input  logic [`TS3D_GBF_ADDR_WIDTH-1:0] rd_addr,
    output gbf_word_t                       rd_data
);

    // storage array
    logic [`TS3D_PORT_WIDTH-1:0] mem [`TS3D_GBF_DEPTH];

    // write side
    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // read data is valid one cycle after rd_en
    // output holds its last word between reads
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

// File: verilog/ts3d_pkg.sv
// buffer word union, buffer write struct and dispatched block struct
`include "ts3d_settings.svh"

package ts3d_pkg;

    // ============================================================
    // buffer word
    // ============================================================

    // one port word, read either as activation bytes or as flag vectors
    // element 0 sits at the low end in both views
    typedef union packed {
        logic [`TS3D_ACTS_PER_WORD-1:0][`TS3D_DATA_WIDTH-1:0]  act;
        logic [`TS3D_FLGS_PER_WORD-1:0][`TS3D_BLOCK_DEPTH-1:0] flg;
    } gbf_word_t;

    // ============================================================
    // port structs
    // ============================================================

    // one write into a global buffer
    typedef struct packed {
        logic                            en;
        logic [`TS3D_GBF_ADDR_WIDTH-1:0] addr;
        gbf_word_t                       data;
    } gbf_wr_t;

    // one dense activation block
    // flags mark the positions that came from the buffer
    typedef struct packed {
        logic [`TS3D_BLOCK_DEPTH-1:0]                        flags;
        logic [`TS3D_BLOCK_DEPTH-1:0][`TS3D_DATA_WIDTH-1:0]  acts;
    } act_block_t;

endpackage

// File: verilog/ts3d_settings.svh
// width and depth macros for the activation feed path
`ifndef TS3D_SETTINGS_SVH
`define TS3D_SETTINGS_SVH

// ============================================================
// data widths
// ============================================================

// one global buffer port word
`define TS3D_PORT_WIDTH 64

// one activation value
`define TS3D_DATA_WIDTH 8

// activations per block, also the flag vector width
`define TS3D_BLOCK_DEPTH 16

// slices of each kind packed in one port word
`define TS3D_ACTS_PER_WORD (`TS3D_PORT_WIDTH / `TS3D_DATA_WIDTH)
`define TS3D_FLGS_PER_WORD (`TS3D_PORT_WIDTH / `TS3D_BLOCK_DEPTH)

// ============================================================
// global buffer geometry
// ============================================================

`define TS3D_GBF_ADDR_WIDTH 8
`define TS3D_GBF_DEPTH (1 << `TS3D_GBF_ADDR_WIDTH)

// occupancy has to reach the full depth, hence one extra bit
`define TS3D_GBF_CNT_WIDTH 9

`endif
